// File: Bender.yml
package:
  name: rvmulticycle

sources:
  - cpuPkg.sv
  - ctrlIf.sv
  - regFile.sv
  - alu.sv
  - controller.sv
  - datapath.sv
  - cpuTop.sv
  - target: simulation
    files:
      - tbCpu.sv

// File: all.f
cpuPkg.sv
ctrlIf.sv
regFile.sv
alu.sv
controller.sv
datapath.sv
cpuTop.sv
tbCpu.sv

// File: alu.sv
// alu
// Add, subtract, bitwise and/or, signed set-less-than,
// zero flag on the result

`timescale 1ns/1ns

module alu (
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    output cpuPkg::word_t  y,
    output logic           zero
);
    import cpuPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluSlt:  y = {{(xlen-1){1'b0}}, lessThan};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: controller.sv
// controller
// Main FSM of the multicycle core with Moore control outputs,
// ALU decoder and immediate-format decoder

`timescale 1ns/1ns

module controller (
    input  logic clk,
    input  logic rst,
    ctrlIf.controller ctl
);
    import cpuPkg::*;

    state_t    state;
    state_t    nextState;
    opcode_t   opcode;
    aluClass_t aluClass;
    logic      pcUpdate;
    logic      branch;

    assign opcode = opcode_t'(ctl.instr.r.opcode);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = sFetch;
        case (state)
            sFetch:  nextState = sDecode;
            sDecode: begin
                case (opcode)
                    opLoad, opStore: nextState = sMemAdr;
                    opRtype:         nextState = sExecR;
                    opItype:         nextState = sExecI;
                    opJal:           nextState = sJal;
                    opBranch:        nextState = sBeq;
                    default:         nextState = sFetch; // unknown opcode
                endcase
            end
            sMemAdr: begin
                if (opcode == opLoad) begin
                    nextState = sMemRead;
                end else begin
                    nextState = sMemWrite;
                end
            end
            sMemRead: nextState = sMemWb;
            sExecR, sExecI, sJal: nextState = sAluWb;
            default: nextState = sFetch; // writeback, store, beq
        endcase
    end

    // Moore outputs decoded from the state
    always_comb begin
        pcUpdate      = 1'b0;
        branch        = 1'b0;
        ctl.adrSrc    = 1'b0;
        ctl.memWrite  = 1'b0;
        ctl.irWrite   = 1'b0;
        ctl.regWrite  = 1'b0;
        ctl.resultSrc = resAluOut;
        ctl.srcASel   = srcPc;
        ctl.srcBSel   = srcRegB;
        aluClass      = clsAddr;
        case (state)
            sFetch: begin
                ctl.irWrite   = 1'b1;
                pcUpdate      = 1'b1;
                ctl.resultSrc = resAluResult; // pc + 4 straight from ALU
                ctl.srcBSel   = srcFour;
            end
            sDecode: begin
                ctl.srcASel = srcOldPc; // branch target into aluOut
                ctl.srcBSel = srcImm;
            end
            sMemAdr: begin
                ctl.srcASel = srcRegA;
                ctl.srcBSel = srcImm;
            end
            sMemRead: ctl.adrSrc = 1'b1;
            sMemWb: begin
                ctl.regWrite  = 1'b1;
                ctl.resultSrc = resData;
            end
            sMemWrite: begin
                ctl.adrSrc   = 1'b1;
                ctl.memWrite = 1'b1;
            end
            sExecR: begin
                ctl.srcASel = srcRegA;
                aluClass    = clsFunct;
            end
            sExecI: begin
                ctl.srcASel = srcRegA;
                ctl.srcBSel = srcImm;
                aluClass    = clsFunct;
            end
            sJal: begin
                pcUpdate    = 1'b1; // target from decode
                ctl.srcASel = srcOldPc;
                ctl.srcBSel = srcFour;
            end
            sAluWb: ctl.regWrite = 1'b1;
            sBeq: begin
                branch      = 1'b1;
                ctl.srcASel = srcRegA;
                aluClass    = clsBranch;
            end
            default: ;
        endcase
    end

    assign ctl.pcWrite = pcUpdate | (branch & ctl.zero);

    always_comb begin
        case (aluClass)
            clsAddr:   ctl.aluCtrl = aluAdd;
            clsBranch: ctl.aluCtrl = aluSub;
            default: begin
                case (ctl.instr.r.funct3)
                    3'b000: begin
                        // sub only for R-type with funct7 bit 5
                        if (opcode[5] & ctl.instr.r.funct7[5]) begin
                            ctl.aluCtrl = aluSub;
                        end else begin
                            ctl.aluCtrl = aluAdd;
                        end
                    end
                    3'b010:  ctl.aluCtrl = aluSlt;
                    3'b110:  ctl.aluCtrl = aluOr;
                    3'b111:  ctl.aluCtrl = aluAnd;
                    default: ctl.aluCtrl = aluAdd;
                endcase
            end
        endcase
    end

    always_comb begin
        case (opcode)
            opStore:  ctl.immSrc = immS;
            opBranch: ctl.immSrc = immB;
            opJal:    ctl.immSrc = immJ;
            default:  ctl.immSrc = immI; // loads and I-type
        endcase
    end

endmodule

// File: cpuPkg.sv
// cpuPkg
// Shared widths, opcodes, ALU operations, select encodings,
// FSM states and instruction views of the multicycle RISC-V core

package cpuPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRtype  = 7'b0110011,
        opItype  = 7'b0010011,
        opJal    = 7'b1101111,
        opBranch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOp_t;

    typedef enum logic [1:0] {clsAddr, clsBranch, clsFunct} aluClass_t;
    typedef enum logic [1:0] {immI, immS, immB, immJ} immSrc_t;
    typedef enum logic [1:0] {srcPc, srcOldPc, srcRegA} srcASel_t;
    typedef enum logic [1:0] {srcRegB, srcImm, srcFour} srcBSel_t;
    typedef enum logic [1:0] {resAluOut, resData, resAluResult} resultSel_t;

    typedef enum logic [3:0] {
        sFetch, sDecode, sMemAdr, sMemRead, sMemWb, sMemWrite,
        sExecR, sAluWb, sExecI, sJal, sBeq
    } state_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            regAddr_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [12:0] unused;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0]  immHi;
            logic [12:0] unused;
            logic [4:0]  immLo;
            logic [6:0]  opcode;
        } s;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10to5;
            logic [12:0] unused;
            logic [3:0]  imm4to1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10to1;
            logic        imm11;
            logic [7:0]  imm19to12;
            regAddr_t    rd;
            logic [6:0]  opcode;
        } j;
    } instr_t;

endpackage

// File: cpuTests.mem
// header: number of program words, number of expected stores
// then program address/word pairs, then expected stores as address/data pairs in order
00000022 0000000D
00400000 00700093 // addi x1, x0, 7
00400004 FFD00113 // addi x2, x0, -3
00400008 10000293 // addi x5, x0, 0x100
0040000C 002081B3 // add x3, x1, x2
00400010 0032A023 // sw x3, 0(x5)
00400014 40208233 // sub x4, x1, x2
00400018 0042A223 // sw x4, 4(x5)
0040001C 0020F333 // and x6, x1, x2
00400020 0062A423 // sw x6, 8(x5)
00400024 0020E3B3 // or x7, x1, x2
00400028 0072A623 // sw x7, 12(x5)
0040002C 00112433 // slt x8, x2, x1
00400030 0082A823 // sw x8, 16(x5)
00400034 0020A4B3 // slt x9, x1, x2
00400038 0092AA23 // sw x9, 20(x5)
0040003C FFF12513 // slti x10, x2, -1
00400040 FEA2AE23 // sw x10, -4(x5)
00400044 0F017593 // andi x11, x2, 0xf0
00400048 FF05E613 // ori x12, x11, -16
0040004C FEC2AC23 // sw x12, -8(x5)
00400050 0002A683 // lw x13, 0(x5)
00400054 00D2AC23 // sw x13, 24(x5)
00400058 00500013 // addi x0, x0, 5
0040005C 0002AE23 // sw x0, 28(x5)
00400060 00108463 // beq x1, x1, +8 taken
00400064 0212A023 // sw x1, 32(x5) skipped
00400068 00208463 // beq x1, x2, +8 not taken
0040006C 0222A223 // sw x2, 36(x5)
00400070 0080076F // jal x14, +8
00400074 0212A423 // sw x1, 40(x5) skipped
00400078 02E2A623 // sw x14, 44(x5)
0040007C FFF0A793 // slti x15, x1, -1
00400080 02F2A823 // sw x15, 48(x5)
00400084 00000063 // beq x0, x0, 0 idle loop
00000100 00000004 // add
00000104 0000000A // sub
00000108 00000005 // and
0000010C FFFFFFFF // or
00000110 00000001 // slt true
00000114 00000000 // slt false
000000FC 00000001 // slti with -1, negative offset
000000F8 FFFFFFF0 // andi then ori
00000118 00000004 // lw read back
0000011C 00000000 // x0 stays zero
00000124 FFFFFFFD // fall-through sentinel
0000012C 00400074 // jal return address
00000130 00000000 // slti against -1 false

// File: cpuTop.sv
// cpuTop
// Multicycle RISC-V core, controller and datapath joined
// by the control interface, plain memory port outside

`timescale 1ns/1ns

module cpuTop #(
    parameter cpuPkg::word_t resetVector = 32'h0040_0000
) (
    input  logic          clk,
    input  logic          rst,
    output cpuPkg::word_t memAdr,
    output cpuPkg::word_t memWriteData,
    output logic          memWrite,
    input  cpuPkg::word_t memReadData
);

    ctrlIf ctl ();

    controller controller_i (
        .clk (clk),
        .rst (rst),
        .ctl (ctl.controller)
    );

    datapath #(
        .resetVector (resetVector)
    ) datapath_i (
        .clk          (clk),
        .rst          (rst),
        .ctl          (ctl.datapath),
        .memAdr       (memAdr),
        .memWriteData (memWriteData),
        .memReadData  (memReadData)
    );

    assign memWrite = ctl.memWrite; // one-cycle store strobe

endmodule

// File: ctrlIf.sv
// ctrlIf
// Control word from the controller to the datapath,
// instruction register and zero flag back

`timescale 1ns/1ns

interface ctrlIf;
    import cpuPkg::*;

    logic       pcWrite;
    logic       adrSrc;
    logic       memWrite;
    logic       irWrite;
    logic       regWrite;
    resultSel_t resultSrc;
    srcASel_t   srcASel;
    srcBSel_t   srcBSel;
    aluOp_t     aluCtrl;
    immSrc_t    immSrc;
    instr_t     instr;
    logic       zero;

    modport controller (
        output pcWrite, adrSrc, memWrite, irWrite, regWrite,
        output resultSrc, srcASel, srcBSel, aluCtrl, immSrc,
        input  instr, zero
    );

    modport datapath (
        input  pcWrite, adrSrc, memWrite, irWrite, regWrite,
        input  resultSrc, srcASel, srcBSel, aluCtrl, immSrc,
        output instr, zero
    );

endinterface

// File: datapath.sv
// datapath
// PC, instruction and old-PC registers, operand and result registers,
// immediate extender and the operand, result and address selects

`timescale 1ns/1ns

module datapath #(
    parameter cpuPkg::word_t resetVector = 32'h0040_0000
) (
    input  logic          clk,
    input  logic          rst,
    ctrlIf.datapath       ctl,
    output cpuPkg::word_t memAdr,
    output cpuPkg::word_t memWriteData,
    input  cpuPkg::word_t memReadData
);
    import cpuPkg::*;

    word_t pc;
    word_t oldPc;
    word_t regA;
    word_t regB;
    word_t aluOut;
    word_t dataReg;
    word_t rd1;
    word_t rd2;
    word_t immExt;
    word_t srcA;
    word_t srcB;
    word_t aluResult;
    word_t result;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetVector;
        end else if (ctl.pcWrite) begin
            pc <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl.instr <= '0;
            oldPc     <= '0;
        end else if (ctl.irWrite) begin
            ctl.instr <= memReadData;
            oldPc     <= pc; // pc of the fetched instruction
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regA    <= '0;
            regB    <= '0;
            aluOut  <= '0;
            dataReg <= '0;
        end else begin
            regA    <= rd1;
            regB    <= rd2;
            aluOut  <= aluResult;
            dataReg <= memReadData;
        end
    end

    regFile regFile_i (
        .clk (clk),
        .rst (rst),
        .we  (ctl.regWrite),
        .ra1 (ctl.instr.r.rs1),
        .ra2 (ctl.instr.r.rs2),
        .wa  (ctl.instr.r.rd),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        case (ctl.immSrc)
            immI: immExt = {{20{ctl.instr.i.imm[11]}}, ctl.instr.i.imm};
            immS: immExt = {{20{ctl.instr.s.immHi[6]}}, ctl.instr.s.immHi, ctl.instr.s.immLo};
            immB: immExt = {{19{ctl.instr.b.imm12}}, ctl.instr.b.imm12, ctl.instr.b.imm11,
                            ctl.instr.b.imm10to5, ctl.instr.b.imm4to1, 1'b0};
            immJ: immExt = {{11{ctl.instr.j.imm20}}, ctl.instr.j.imm20, ctl.instr.j.imm19to12,
                            ctl.instr.j.imm11, ctl.instr.j.imm10to1, 1'b0};
            default: immExt = '0;
        endcase
    end

    always_comb begin
        case (ctl.srcASel)
            srcPc:    srcA = pc;
            srcOldPc: srcA = oldPc;
            srcRegA:  srcA = regA;
            default:  srcA = '0;
        endcase
    end

    always_comb begin
        case (ctl.srcBSel)
            srcRegB: srcB = regB;
            srcImm:  srcB = immExt;
            srcFour: srcB = xlen'(4);
            default: srcB = '0;
        endcase
    end

    alu alu_i (
        .op   (ctl.aluCtrl),
        .a    (srcA),
        .b    (srcB),
        .y    (aluResult),
        .zero (ctl.zero)
    );

    always_comb begin
        case (ctl.resultSrc)
            resAluOut:    result = aluOut;
            resData:      result = dataReg;
            resAluResult: result = aluResult;
            default:      result = '0;
        endcase
    end

    assign memAdr       = ctl.adrSrc ? result : pc; // data access or fetch
    assign memWriteData = regB;

endmodule

// File: regFile.sv
// regFile
// 32 x 32-bit register file, two combinational reads, one write,
// x0 reads as zero

`timescale 1ns/1ns

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  cpuPkg::regAddr_t ra1,
    input  cpuPkg::regAddr_t ra2,
    input  cpuPkg::regAddr_t wa,
    input  cpuPkg::word_t    wd,
    output cpuPkg::word_t    rd1,
    output cpuPkg::word_t    rd2
);
    import cpuPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: tbCpu.sv
// tbCpu
// Testbench for the multicycle core with a memory model loaded from the tests file,
// an in-order store checker against the expected store list and a watchdog

`timescale 1ns/1ns

module tbCpu;
    import cpuPkg::*;

    localparam time clkPeriod   = 40;
    localparam time driveDelay  = 2;
    localparam int  resetCycles = 5;
    localparam int  maxWords    = 256;
    localparam int  tailCycles  = 10; // idle loop after the last store

    logic  clk;
    logic  rst;
    word_t memAdr;
    word_t memWriteData;
    logic  memWrite;
    word_t memReadData;

    word_t tests [maxWords];
    word_t mem [word_t];
    word_t expAdr [$];
    word_t expData [$];
    int    progWords;
    int    storeCount;
    int    storesSeen;
    bit    loaded;
    bit    armed;

    cpuTop #(
        .resetVector (32'h0040_0000)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .memAdr       (memAdr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memReadData  (memReadData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // unwritten locations answer with an address-dependent pattern
    function automatic word_t fillWord(input word_t adr);
        return adr ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t readWord(input word_t adr);
        if ($isunknown(adr)) begin
            return '0;
        end
        if (mem.exists(adr)) begin
            return mem[adr];
        end
        return fillWord(adr);
    endfunction

    // memory answers the current address shortly after each edge
    always @(posedge clk) begin
        #driveDelay;
        memReadData = readWord(memAdr);
    end

    initial begin
        int base;
        clk         = 1'b0;
        rst         = 1'b1;
        memReadData = '0;
        storesSeen  = 0;
        progWords   = 0;
        storeCount  = 0;
        $readmemh("cpuTests.mem", tests);
        if ($isunknown(tests[0]) || $isunknown(tests[1])) begin
            $display("tests file could not be read or has no header line");
            abortRun();
        end
        progWords  = tests[0];
        storeCount = tests[1];
        base       = 2 + 2 * progWords;
        if (base + 2 * storeCount > maxWords || storeCount == 0) begin
            $display("tests file header gives %0d words and %0d stores, which do not fit",
                     progWords, storeCount);
            abortRun();
        end
        if ($isunknown(tests[base + 2 * storeCount - 1])) begin
            $display("tests file is shorter than its header says");
            abortRun();
        end
        for (int i = 0; i < progWords; i++) begin
            mem[tests[2 + 2 * i]] = tests[3 + 2 * i];
        end
        for (int i = 0; i < storeCount; i++) begin
            expAdr.push_back(tests[base + 2 * i]);
            expData.push_back(tests[base + 2 * i + 1]);
        end
        loaded = 1'b1;
        @(posedge clk);
        armed = 1'b1; // state is defined after the first reset edge
        repeat (resetCycles - 1) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        wait (storesSeen == storeCount);
        repeat (tailCycles) @(posedge clk); // stray stores still get caught
        $display("PASS: all tests");
        $finish;
    end

    // stores are checked and committed mid-cycle where the port is stable
    always @(negedge clk) begin
        if (armed) begin
            assert (!$isunknown(memWrite)) else begin
                $display("memWrite is unknown at time %0t", $time);
                abortRun();
            end
            assert (!(rst && memWrite)) else begin
                $display("store strobe raised during reset at time %0t", $time);
                abortRun();
            end
            if (memWrite) begin
                assert (storesSeen < storeCount) else begin
                    $display("unexpected store of %h to %h at time %0t after the last one",
                             memWriteData, memAdr, $time);
                    abortRun();
                end
                assert (memAdr === expAdr[storesSeen]) else begin
                    $display("CHECK FAILED at time %0t: memAdr expected %h, got %h",
                             $time, expAdr[storesSeen], memAdr);
                    abortRun();
                end
                assert (memWriteData === expData[storesSeen]) else begin
                    $display("CHECK FAILED at time %0t: memWriteData expected %h, got %h",
                             $time, expData[storesSeen], memWriteData);
                    abortRun();
                end
                mem[memAdr] = memWriteData;
                storesSeen++;
            end
        end
    end

    initial begin
        wait (loaded);
        #((6 * progWords + 200) * clkPeriod);
        $display("timeout: only %0d of %0d expected stores appeared", storesSeen, storeCount);
        abortRun();
    end

endmodule
